// ==== include/lz77_tile_defs.svh ====
// ----------------------------------------------------------------------
// lz77 tile widths, depths and credit counts.
// shared by the packages and the RTL of the match-search tile.
// ----------------------------------------------------------------------
`ifndef LZ77_TILE_DEFS_SVH
`define LZ77_TILE_DEFS_SVH

// bytes per input word and history depth, which is also the largest offset.
`define LZ_IN_BYTES     4
`define LZ_HIST_BYTES   16

// offsets handled by one bank.
`define LZ_OFFS_PER_LPO 8

// input queue depth and output credits.
`define LZ_IN_CREDITS   4
`define LZ_OUT_CREDITS  4

// run length saturates here.
`define LZ_RUN_MAX      63
`define LZ_LEN_W        6
`define LZ_OFF_W        4
`define LZ_FILL_W       5

`endif

// ==== source/lz77_data_pkg.sv ====
// ----------------------------------------------------------------------
// lz77 data types.
// describes the input byte stream and the history window seen by a word.
// ----------------------------------------------------------------------
`include "lz77_tile_defs.svh"

package lz77_data_pkg;

   // ------------------------------------------------------------------
   // input stream.
   // ------------------------------------------------------------------

   // byte 0 is the earliest byte of the word in the stream.
   typedef struct packed {
      logic [`LZ_IN_BYTES-1:0][7:0] data;
      logic                         first;
   } in_beat_t;

   // ------------------------------------------------------------------
   // history window.
   // ------------------------------------------------------------------

   // index 0 is the most recent byte, fill counts the valid ones.
   typedef struct packed {
      logic [`LZ_HIST_BYTES-1:0][7:0] bytes;
      logic [`LZ_FILL_W-1:0]          fill;
   } hist_win_t;

endpackage

// ==== source/lz77_match_pkg.sv ====
// ----------------------------------------------------------------------
// lz77 match types.
// bank and tile match results, and the tile control states.
// ----------------------------------------------------------------------
`include "lz77_tile_defs.svh"

package lz77_match_pkg;

   // ------------------------------------------------------------------
   // results.
   // ------------------------------------------------------------------

   // best of one bank, offset is tile-wide and stored as offset minus 1.
   typedef struct packed {
      logic [`LZ_OFF_W-1:0] offset;
      logic [`LZ_LEN_W-1:0] len;
   } lpo_best_t;

   // merged result of the tile.
   typedef struct packed {
      logic [`LZ_OFF_W-1:0] offset;
      logic [`LZ_LEN_W-1:0] len;
   } match_res_t;

   // ------------------------------------------------------------------
   // control.
   // ------------------------------------------------------------------

   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_RUN   = 2'd1,
      ST_DRAIN = 2'd2
   } tile_state_e;

endpackage

// ==== source/lz77_hist_buf.sv ====
// ----------------------------------------------------------------------
// lz77 history buffer.
// shift register of the last stream bytes with a saturating fill count.
// presents the window seen by the word being issued.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "lz77_tile_defs.svh"

module lz77_hist_buf (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     issue,
   input  lz77_data_pkg::in_beat_t  issue_beat,
   output lz77_data_pkg::hist_win_t hist
);
   import lz77_data_pkg::*;

   localparam int NB     = `LZ_IN_BYTES;
   localparam int HB     = `LZ_HIST_BYTES;
   localparam int FILL_W = `LZ_FILL_W;
   localparam logic [FILL_W-1:0] FILL_MAX  = FILL_W'(HB);
   localparam logic [FILL_W-1:0] FILL_STEP = FILL_W'(NB);

   logic [HB-1:0][7:0] bytes_q;
   logic [HB-1:0][7:0] bytes_nxt;
   logic [FILL_W-1:0]  fill_q;
   logic [FILL_W-1:0]  fill_nxt;

   // a new stream sees an empty window.
   always_comb begin
      hist.bytes = bytes_q;
      hist.fill  = fill_q;
      if (issue && issue_beat.first) begin
         hist = '0;
      end
   end

   // older bytes move up by one word, newest byte lands at index 0.
   always_comb begin
      bytes_nxt = hist.bytes << (8 * NB);
      for (int i = 0; i < NB; i++) begin
         bytes_nxt[i] = issue_beat.data[NB-1-i];
      end
      if (hist.fill > (FILL_MAX - FILL_STEP)) begin
         fill_nxt = FILL_MAX;
      end else begin
         fill_nxt = hist.fill + FILL_STEP;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         bytes_q <= bytes_nxt;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fill_q <= '0;
      end else if (issue) begin
         fill_q <= fill_nxt;
      end
   end

   a_fill_range : assert property (
      @(posedge clk) disable iff (!rst_n) fill_q <= FILL_MAX
   ) else $error("history fill above depth: %0d", fill_q);

endmodule

// ==== source/lz77_lpo.sv ====
// ----------------------------------------------------------------------
// lz77 offset bank.
// compares the issued word against history for a group of offsets,
// keeps one run counter per offset and registers the best of the bank.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "lz77_tile_defs.svh"

module lz77_lpo #(
   parameter int BANK = 0
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      issue,
   input  lz77_data_pkg::in_beat_t   issue_beat,
   input  lz77_data_pkg::hist_win_t  hist,
   output logic                      lpo_valid,
   output lz77_match_pkg::lpo_best_t lpo_best
);
   import lz77_data_pkg::*;
   import lz77_match_pkg::*;

   localparam int NB     = `LZ_IN_BYTES;
   localparam int HB     = `LZ_HIST_BYTES;
   localparam int NO     = `LZ_OFFS_PER_LPO;
   localparam int EXT    = HB + NB;
   localparam int LEN_W  = `LZ_LEN_W;
   localparam int OFF_W  = `LZ_OFF_W;
   localparam int LEAD_W = $clog2(NB + 1);
   localparam logic [LEN_W:0]  RUN_MAX  = (LEN_W + 1)'(`LZ_RUN_MAX);
   localparam logic [LEN_W:0]  RUN_STEP = (LEN_W + 1)'(NB);
   localparam logic [LEAD_W-1:0] FULL   = LEAD_W'(NB);

   logic [EXT-1:0][7:0]       ext;
   logic [EXT-1:0]            ext_ok;
   logic [NO-1:0][NB-1:0]     hit;
   logic [NO-1:0][LEAD_W-1:0] lead;
   logic [NO-1:0][LEN_W:0]    run_sum;
   logic [NO-1:0][LEN_W-1:0]  run_q;
   logic [NO-1:0][LEN_W-1:0]  run_nxt;
   lpo_best_t                 best_nxt;

   // ------------------------------------------------------------------
   // compare matrix.
   // ------------------------------------------------------------------

   // stream order, ext[HB] is word byte 0 and ext[HB-1] the newest history.
   always_comb begin
      for (int n = 0; n < HB; n++) begin
         ext[n]    = hist.bytes[HB-1-n];
         ext_ok[n] = (HB - n) <= int'(hist.fill);
      end
      for (int i = 0; i < NB; i++) begin
         ext[HB+i]    = issue_beat.data[i];
         ext_ok[HB+i] = 1'b1;
      end
   end

   // offset d = BANK*NO + j + 1, may reach into the current word.
   always_comb begin
      for (int j = 0; j < NO; j++) begin
         for (int i = 0; i < NB; i++) begin
            hit[j][i] = ext_ok[HB+i-(BANK*NO+j+1)] &&
                        (ext[HB+i] == ext[HB+i-(BANK*NO+j+1)]);
         end
      end
   end

   // ------------------------------------------------------------------
   // run counters and best in bank.
   // ------------------------------------------------------------------

   always_comb begin
      for (int j = 0; j < NO; j++) begin
         // leading matches, a miss restarts the count.
         lead[j] = '0;
         for (int i = NB - 1; i >= 0; i--) begin
            if (hit[j][i]) begin
               lead[j] = lead[j] + 1'b1;
            end else begin
               lead[j] = '0;
            end
         end
         run_sum[j] = {1'b0, run_q[j]} + RUN_STEP;
         if (issue_beat.first) begin
            run_nxt[j] = '0;
         end else if (lead[j] == FULL) begin
            run_nxt[j] = (run_sum[j] > RUN_MAX) ? RUN_MAX[LEN_W-1:0] : run_sum[j][LEN_W-1:0];
         end else begin
            run_nxt[j] = LEN_W'(lead[j]);
         end
      end
   end

   // strict compare keeps the smallest offset on a tie.
   always_comb begin
      best_nxt.offset = OFF_W'(BANK * NO);
      best_nxt.len    = run_nxt[0];
      for (int j = 1; j < NO; j++) begin
         if (run_nxt[j] > best_nxt.len) begin
            best_nxt.offset = OFF_W'(BANK * NO + j);
            best_nxt.len    = run_nxt[j];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run_q     <= '0;
         lpo_valid <= 1'b0;
      end else begin
         lpo_valid <= issue;
         if (issue) begin
            run_q <= run_nxt;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         lpo_best <= best_nxt;
      end
   end

   a_valid_lat : assert property (
      @(posedge clk) disable iff (!rst_n) lpo_valid == $past(issue)
   ) else $error("bank %0d result not one cycle after issue", BANK);

endmodule

// ==== source/lz77_tile_ctrl.sv ====
// ----------------------------------------------------------------------
// lz77 tile control.
// input queue with credit return, output credit counter, control FSM
// and the merge of the bank results into the tile result.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "lz77_tile_defs.svh"

module lz77_tile_ctrl #(
   parameter int NUM_LPO = 2
) (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    in_valid,
   input  lz77_data_pkg::in_beat_t                 in_beat,
   output logic                                    in_credit,
   input  logic                                    res_credit,
   output logic                                    issue,
   output lz77_data_pkg::in_beat_t                 issue_beat,
   input  logic [NUM_LPO-1:0]                      lpo_valid,
   input  lz77_match_pkg::lpo_best_t [NUM_LPO-1:0] lpo_best,
   output logic                                    res_valid,
   output lz77_match_pkg::match_res_t              res
);
   import lz77_data_pkg::*;
   import lz77_match_pkg::*;

   localparam int QD  = `LZ_IN_CREDITS;
   localparam int PW  = $clog2(QD);
   localparam int CW  = $clog2(QD + 1);
   localparam int OCW = $clog2(`LZ_OUT_CREDITS + 1);
   localparam logic [CW-1:0]  Q_FULL        = CW'(QD);
   localparam logic [OCW-1:0] OUT_CRED_INIT = OCW'(`LZ_OUT_CREDITS);

   in_beat_t      q_mem [QD];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] q_cnt;
   logic [OCW-1:0] out_cred;
   tile_state_e   state;
   tile_state_e   state_nxt;
   lpo_best_t     merged;

   // ------------------------------------------------------------------
   // input queue and credits.
   // ------------------------------------------------------------------

   // the output credit is taken at pop, so nothing behind stalls.
   assign issue      = (q_cnt != '0) && (out_cred != '0);
   assign issue_beat = q_mem[rd_ptr];
   assign in_credit  = issue;

   always_ff @(posedge clk) begin
      if (in_valid) begin
         q_mem[wr_ptr] <= in_beat;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         q_cnt    <= '0;
         out_cred <= OUT_CRED_INIT;
      end else begin
         if (in_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (issue) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({in_valid, issue})
            2'b10:   q_cnt <= q_cnt + 1'b1;
            2'b01:   q_cnt <= q_cnt - 1'b1;
            default: q_cnt <= q_cnt;
         endcase
         out_cred <= out_cred + OCW'(res_credit) - OCW'(issue);
      end
   end

   // ------------------------------------------------------------------
   // control FSM.
   // ------------------------------------------------------------------

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (issue) begin
               state_nxt = ST_RUN;
            end
         end
         ST_RUN: begin
            if (!issue) begin
               state_nxt = ST_DRAIN;
            end
         end
         ST_DRAIN: begin
            if (issue) begin
               state_nxt = ST_RUN;
            end else if (!(|lpo_valid)) begin
               state_nxt = ST_IDLE;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // ------------------------------------------------------------------
   // merge of bank results.
   // ------------------------------------------------------------------

   // longer run wins, equal runs go to the smaller offset.
   always_comb begin
      merged = lpo_best[0];
      for (int b = 1; b < NUM_LPO; b++) begin
         if ((lpo_best[b].len > merged.len) ||
             ((lpo_best[b].len == merged.len) && (lpo_best[b].offset < merged.offset))) begin
            merged = lpo_best[b];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         res_valid <= 1'b0;
      end else begin
         res_valid <= |lpo_valid;
      end
   end

   always_ff @(posedge clk) begin
      if ((state != ST_IDLE) && (|lpo_valid)) begin
         res.offset <= merged.offset;
         res.len    <= merged.len;
      end
   end

   a_q_no_ovf : assert property (
      @(posedge clk) disable iff (!rst_n) in_valid |-> (q_cnt < Q_FULL)
   ) else $error("input queue overflow, upstream sent without credit");

   a_cred_max : assert property (
      @(posedge clk) disable iff (!rst_n) out_cred <= OUT_CRED_INIT
   ) else $error("output credits above start value: %0d", out_cred);

endmodule

// ==== source/lz77_tile.sv ====
// ----------------------------------------------------------------------
// lz77 match-search tile.
// history buffer, offset banks and tile control on one clock.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "lz77_tile_defs.svh"

module lz77_tile (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       in_valid,
   input  lz77_data_pkg::in_beat_t    in_beat,
   output logic                       in_credit,
   output logic                       res_valid,
   output lz77_match_pkg::match_res_t res,
   input  logic                       res_credit
);
   import lz77_data_pkg::*;
   import lz77_match_pkg::*;

   localparam int NUM_LPO = `LZ_HIST_BYTES / `LZ_OFFS_PER_LPO;

   logic                       issue;
   in_beat_t                   issue_beat;
   hist_win_t                  hist;
   logic [NUM_LPO-1:0]         lpo_valid;
   lpo_best_t [NUM_LPO-1:0]    lpo_best;

   lz77_tile_ctrl #(
      .NUM_LPO (NUM_LPO)
   ) i_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_beat    (in_beat),
      .in_credit  (in_credit),
      .res_credit (res_credit),
      .issue      (issue),
      .issue_beat (issue_beat),
      .lpo_valid  (lpo_valid),
      .lpo_best   (lpo_best),
      .res_valid  (res_valid),
      .res        (res)
   );

   lz77_hist_buf i_hist (
      .clk        (clk),
      .rst_n      (rst_n),
      .issue      (issue),
      .issue_beat (issue_beat),
      .hist       (hist)
   );

   // one bank per group of offsets.
   for (genvar b = 0; b < NUM_LPO; b++) begin : g_lpo
      lz77_lpo #(
         .BANK (b)
      ) i_lpo (
         .clk        (clk),
         .rst_n      (rst_n),
         .issue      (issue),
         .issue_beat (issue_beat),
         .hist       (hist),
         .lpo_valid  (lpo_valid[b]),
         .lpo_best   (lpo_best[b])
      );
   end

endmodule

// ==== test/tb_clock_gen.sv ====
// ----------------------------------------------------------------------
// testbench clock and reset.
// free running clock and an active low reset held for a few cycles.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // release away from the rising edge.
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

// ==== test/tb_lz77_tile.sv ====
// ----------------------------------------------------------------------
// lz77 tile testbench.
// credit based sender and result sink, a reference model of the match
// rule and a compare process that checks every result in order.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "lz77_tile_defs.svh"

module tb_lz77_tile;
   import lz77_data_pkg::*;
   import lz77_match_pkg::*;

   localparam int NB         = `LZ_IN_BYTES;
   localparam int HB         = `LZ_HIST_BYTES;
   localparam int IN_CRED    = `LZ_IN_CREDITS;
   localparam int OUT_CRED   = `LZ_OUT_CREDITS;
   localparam int RUN_MAX    = `LZ_RUN_MAX;
   localparam int OFF_W      = `LZ_OFF_W;
   localparam int LEN_W      = `LZ_LEN_W;
   localparam int WAIT_LIMIT = 2000;

   logic       clk;
   logic       rst_n;
   logic       in_valid;
   in_beat_t   in_beat;
   logic       in_credit;
   logic       res_valid;
   match_res_t res;
   logic       res_credit;

   match_res_t  exp_q [$];
   logic [7:0]  ref_tail [$];
   int          ref_run [HB];
   int unsigned stim_rng = 32'd4349;
   int unsigned cred_rng = 32'd4349;
   int          up_credits = IN_CRED;
   int          owed;
   int          sent;
   int          rx_count;
   int          mism_cnt;
   int          fail_cnt;
   bit          hold_credits;
   bit          aborted;

   tb_clock_gen #(
      .PERIOD_NS    (8),
      .RESET_CYCLES (10)
   ) i_clk (
      .clk   (clk),
      .rst_n (rst_n)
   );

   lz77_tile i_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_beat    (in_beat),
      .in_credit  (in_credit),
      .res_valid  (res_valid),
      .res        (res),
      .res_credit (res_credit)
   );

   // ------------------------------------------------------------------
   // helpers.
   // ------------------------------------------------------------------

   function automatic int unsigned lcg_next(inout int unsigned state);
      state = state * 32'd1103515245 + 32'd12345;
      return state >> 16;
   endfunction

   // small alphabet so that matches are common.
   function automatic logic [31:0] rand_word();
      logic [31:0] w;
      for (int i = 0; i < NB; i++) begin
         w[8*i +: 8] = 8'h41 + 8'(lcg_next(stim_rng) % 3);
      end
      return w;
   endfunction

   task automatic check_value(input string name, input int got, input int expected);
      if (got != expected) begin
         $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, expected);
         mism_cnt++;
      end
   endtask

   task automatic report_failure(input string msg);
      $display("error at %0t: %s", $time, msg);
      fail_cnt++;
   endtask

   // ------------------------------------------------------------------
   // reference model.
   // ------------------------------------------------------------------

   // tail holds the stream since the last first flag with the oldest byte first.
   function automatic match_res_t ref_match(input in_beat_t beat);
      match_res_t r;
      logic [7:0] ext [$];
      int         n;
      int         k;
      int         pos;
      int         best_d;
      int         best_len;
      bit         miss;
      if (beat.first) begin
         ref_tail.delete();
         for (int d = 0; d < HB; d++) begin
            ref_run[d] = 0;
         end
      end
      n   = ref_tail.size();
      ext = ref_tail;
      for (int i = 0; i < NB; i++) begin
         ext.push_back(beat.data[i]);
      end
      best_d   = 1;
      best_len = 0;
      for (int d = 1; d <= HB; d++) begin
         k    = 0;
         miss = 1'b0;
         for (int i = 0; i < NB; i++) begin
            pos = n + i - d;
            if (!miss && pos >= 0 && ext[pos] == ext[n+i]) begin
               k++;
            end else begin
               miss = 1'b1;
            end
         end
         if (beat.first) begin
            ref_run[d-1] = 0;
         end else if (k == NB) begin
            ref_run[d-1] = (ref_run[d-1] + NB > RUN_MAX) ? RUN_MAX : ref_run[d-1] + NB;
         end else begin
            ref_run[d-1] = k;
         end
         if (ref_run[d-1] > best_len) begin
            best_len = ref_run[d-1];
            best_d   = d;
         end
      end
      for (int i = 0; i < NB; i++) begin
         ref_tail.push_back(beat.data[i]);
      end
      while (ref_tail.size() > HB) begin
         void'(ref_tail.pop_front());
      end
      r.offset = OFF_W'(best_d - 1);
      r.len    = LEN_W'(best_len);
      return r;
   endfunction

   // ------------------------------------------------------------------
   // upstream side.
   // ------------------------------------------------------------------

   task automatic next_edge();
      @(posedge clk);
      if (rst_n && in_credit) begin
         up_credits++;
      end
      if (up_credits > IN_CRED) begin
         report_failure("input credits returned beyond the queue depth");
      end
      in_valid <= 1'b0;
   endtask

   task automatic send_word(input logic [31:0] data, input logic first);
      in_beat_t beat;
      int       cycles;
      beat.data  = data;
      beat.first = first;
      cycles     = 0;
      next_edge();
      while (!aborted && up_credits == 0) begin
         next_edge();
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            report_failure("timeout waiting for an input credit");
            aborted = 1'b1;
         end
      end
      if (!aborted) begin
         in_valid <= 1'b1;
         in_beat  <= beat;
         up_credits--;
         exp_q.push_back(ref_match(beat));
         sent++;
      end
   endtask

   task automatic wait_all_results();
      int cycles;
      cycles = 0;
      while (!aborted && rx_count != sent) begin
         next_edge();
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            report_failure("timeout waiting for outstanding results");
            aborted = 1'b1;
         end
      end
   endtask

   task automatic finish_run();
      $display("errors: %0d mismatches, %0d other failures, %0d of %0d results checked",
               mism_cnt, fail_cnt, rx_count, sent);
      if (mism_cnt == 0 && fail_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   endtask

   // ------------------------------------------------------------------
   // result side.
   // ------------------------------------------------------------------

   always @(posedge clk) begin : compare_results
      match_res_t expected;
      if (rst_n && res_valid) begin
         if (exp_q.size() == 0) begin
            report_failure("result arrived with no word outstanding");
         end else begin
            expected = exp_q.pop_front();
            check_value("res.offset", int'(res.offset), int'(expected.offset));
            check_value("res.len", int'(res.len), int'(expected.len));
         end
         rx_count <= rx_count + 1;
      end
   end

   // one credit back per received result at a random pace.
   initial begin : return_credits
      res_credit = 1'b0;
      forever begin
         @(posedge clk);
         if (!rst_n) begin
            owed = 0;
            res_credit <= 1'b0;
         end else begin
            if (res_valid) begin
               owed++;
            end
            if (owed > OUT_CRED) begin
               report_failure("more results than output credits");
            end
            if (!hold_credits && owed > 0 && (lcg_next(cred_rng) % 4) != 0) begin
               res_credit <= 1'b1;
               owed--;
            end else begin
               res_credit <= 1'b0;
            end
         end
      end
   end

   // ------------------------------------------------------------------
   // test sequence.
   // ------------------------------------------------------------------

   initial begin
      logic [31:0] word;
      logic        first;
      int          base;
      int          cycles;
      in_valid     = 1'b0;
      in_beat      = '0;
      hold_credits = 1'b0;

      // reset and idle.
      cycles = 0;
      while (!aborted && !rst_n) begin
         next_edge();
         check_value("in_credit", int'(in_credit), 0);
         check_value("res_valid", int'(res_valid), 0);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            report_failure("reset was never released");
            aborted = 1'b1;
         end
      end
      repeat (16) begin
         next_edge();
         check_value("in_credit", int'(in_credit), 0);
         check_value("res_valid", int'(res_valid), 0);
      end

      // all-zero stream where the run grows by 4 and saturates.
      send_word(32'h0, 1'b1);
      repeat (19) send_word(32'h0, 1'b0);
      wait_all_results();

      // random streams with restarts and gaps.
      for (int w = 0; w < 150; w++) begin
         word  = rand_word();
         first = (lcg_next(stim_rng) % 12) == 0;
         send_word(word, first);
         if ((lcg_next(stim_rng) % 4) == 0) begin
            next_edge();
         end
      end
      wait_all_results();

      // restart on a word that repeats the old history.
      send_word(32'h44434241, 1'b1);
      repeat (5) send_word(32'h44434241, 1'b0);
      send_word(32'h44434241, 1'b1);
      repeat (3) send_word(32'h44434241, 1'b0);
      wait_all_results();

      // output back-pressure starting with every credit home.
      cycles = 0;
      while (!aborted && owed != 0) begin
         next_edge();
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            report_failure("timeout waiting for result credits to return");
            aborted = 1'b1;
         end
      end
      hold_credits <= 1'b1;
      base = rx_count;
      repeat (OUT_CRED + IN_CRED) send_word(rand_word(), 1'b0);
      cycles = 0;
      while (!aborted && rx_count - base < OUT_CRED) begin
         next_edge();
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            report_failure("timeout waiting for results under back-pressure");
            aborted = 1'b1;
         end
      end
      repeat (24) next_edge();
      check_value("results with credits held", rx_count - base, OUT_CRED);
      check_value("upstream credits with queue full", up_credits, 0);
      hold_credits <= 1'b0;
      wait_all_results();

      // full-rate sender limited only by its credits.
      for (int w = 0; w < 60; w++) begin
         word = rand_word();
         send_word(word, w == 0);
      end
      wait_all_results();

      // stay idle for a while so that a surplus result would still arrive.
      repeat (16) next_edge();
      check_value("results received", rx_count, sent);
      check_value("expected results left", exp_q.size(), 0);
      finish_run();
   end

endmodule

// ==== lz77_tile.f ====
+incdir+include
source/lz77_data_pkg.sv
source/lz77_match_pkg.sv
source/lz77_hist_buf.sv
source/lz77_lpo.sv
source/lz77_tile_ctrl.sv
source/lz77_tile.sv
test/tb_clock_gen.sv
test/tb_lz77_tile.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_lz77_tile
RTL_TOP   ?= lz77_tile
FILELIST  ?= lz77_tile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

sim: build
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
